//--- src/spu_pkg.sv
package spu_pkg;

	// attribute registers per sprite in the sprite file
	parameter int SF_REGS = 8;

	// --------------------
	// colour modes
	// --------------------
	typedef enum logic [1:0]
	{
		CM_OFF  = 2'd0,		// sprite inactive
		CM_4C   = 2'd1,		// 2-bit index via palette
		CM_16C  = 2'd2,		// 4-bit index via palette
		CM_TRUE = 2'd3		// direct colour
	} color_mode_t;

	// decoded attributes of one sprite
	typedef struct packed
	{
		logic [8:0]  xpos;
		logic [6:0]  xwords;	// row length in 16-bit words
		logic [8:0]  ypos;
		logic [6:0]  ysize4;	// height in units of 4 lines
		logic [5:0]  pal;
		color_mode_t mode;
		logic [20:0] base;
	} sprite_attr_t;

	// one line-buffer location
	typedef struct packed
	{
		logic       opaque;
		logic [5:0] color;
	} pix_entry_t;

	// one direct-colour byte
	typedef struct packed
	{
		logic       spare;
		logic       transp;
		logic [5:0] color;
	} true_pix_t;

	// --------------------
	// dram word, three views
	// --------------------
	typedef union packed
	{
		logic [7:0][1:0] idx2;	// CM_4C, idx2[7] first
		logic [3:0][3:0] idx4;	// CM_16C, idx4[3] first
		true_pix_t [1:0] tc;	// CM_TRUE, tc[1] first
	} fetch_word_u;

	// sequencer to unpacker
	typedef struct packed
	{
		logic        load;		// new word on spu_data
		color_mode_t mode;
		logic [5:0]  pal;
		logic        xpos_load;	// start of a sprite row
		logic [8:0]  xpos;
	} unpack_ctl_t;

endpackage

//--- src/sprite_seq.sv
`timescale 1ns/10ps

module sprite_seq import spu_pkg::*;
#(
	parameter int SPRITE_CNT = 64
)
(
	input  logic         clk,
	input  logic         line_start,
	input  logic         pre_vline,
	output logic [8:0]   sf_ra,
	input  logic [7:0]   sf_rd,
	output logic [20:0]  spu_addr,
	output logic         spu_req,
	input  logic         spu_strobe,
	input  logic         last_pix,
	input  logic         last_word,
	output logic         draw_sel,
	output unpack_ctl_t  unpack_ctl,
	output logic         cnt_load_word,
	output logic         cnt_load_row,
	output logic         cnt_step,
	output logic [6:0]   xwords,
	output color_mode_t  mode
);

	localparam int NUM_W = $clog2(SPRITE_CNT);
	localparam int SUB_W = $clog2(SF_REGS);
	localparam logic [NUM_W-1:0] LAST_NUM = NUM_W'(SPRITE_CNT - 1);

	// register read order: 4 3 2 1 0 5 6 7
	typedef enum logic [3:0]
	{
		S_R4, S_R3, S_R2, S_R1, S_R0, S_R5, S_R6, S_R7,
		S_WAIT,		// spu_req high, waiting for strobe
		S_UNPK,		// one pixel per clock
		S_END,		// end-of-word cycle
		S_HALT
	} seq_state_t;

	seq_state_t        state;
	logic [NUM_W-1:0]  num;		// current sprite
	logic [SUB_W-1:0]  sub;		// register within sprite
	logic [8:0]        vline;
	sprite_attr_t      attr;

	logic        active, vis, last_spr, done_spr;
	logic [8:0]  ypos_c;
	logic [9:0]  yend_c;
	logic [8:0]  line_ofs;
	logic [20:0] row_ofs;

	// --------------------
	// line count
	// --------------------
	// sampled on line_start, survives the reset it also gives
	always_ff @(posedge clk)
		if (line_start)
		begin
			if (pre_vline)
			begin
				vline <= 9'd0;
				draw_sel <= 1'b0;
			end
			else
			begin
				vline <= vline + 9'd1;
				draw_sel <= ~draw_sel;	// swap halves
			end
		end

	// --------------------
	// sprite file address
	// --------------------
	always_comb
		case (state)
			S_R4: sub = SUB_W'(4);
			S_R3: sub = SUB_W'(3);
			S_R2: sub = SUB_W'(2);
			S_R1: sub = SUB_W'(1);
			S_R5: sub = SUB_W'(5);
			S_R6: sub = SUB_W'(6);
			S_R7: sub = SUB_W'(7);
			default: sub = SUB_W'(0);	// S_R0, rest don't care
		endcase

	assign sf_ra = 9'({num, sub});

	// visibility, ypos[8] and ysize4 already latched from reg3
	assign ypos_c = {attr.ypos[8], sf_rd};
	assign yend_c = {1'b0, ypos_c} + {1'b0, attr.ysize4, 2'b00};
	assign vis = (vline >= ypos_c) && ({1'b0, vline} < yend_c);

	assign active = (color_mode_t'(sf_rd[1:0]) != CM_OFF);
	assign last_spr = (num == LAST_NUM);

	// row offset, words per row times lines into sprite
	assign line_ofs = vline - attr.ypos;
	assign row_ofs = 21'(attr.xwords) * 21'(line_ofs);

	// sprite finished: inactive, invisible or last word done
	assign done_spr = ((state == S_R4) && !active) ||
		((state == S_R2) && !vis) ||
		((state == S_END) && last_word);

	// --------------------
	// fsm
	// --------------------
	always_ff @(posedge clk or posedge line_start)
		if (line_start)
		begin
			state <= S_R4;
			num <= '0;
			spu_req <= 1'b0;
		end
		else if (done_spr)
		begin
			if (last_spr)
				state <= S_HALT;
			else
			begin
				num <= num + 1'b1;
				state <= S_R4;
			end
		end
		else
			case (state)
				S_R4: state <= S_R3;
				S_R3: state <= S_R2;
				S_R2: state <= S_R1;
				S_R1: state <= S_R0;
				S_R0: state <= S_R5;
				S_R5: state <= S_R6;
				S_R6: state <= S_R7;
				S_R7:
				begin
					spu_req <= 1'b1;	// first word of row
					state <= S_WAIT;
				end
				S_WAIT:
					if (spu_strobe)
					begin
						spu_req <= 1'b0;
						state <= S_UNPK;
					end
				S_UNPK:
					if (last_pix)
						state <= S_END;
				S_END:
				begin
					spu_req <= 1'b1;	// more words to go
					state <= S_WAIT;
				end
				default: state <= S_HALT;
			endcase

	// attribute capture and dram address
	always_ff @(posedge clk)
		case (state)
			S_R4:
			begin
				attr.mode <= color_mode_t'(sf_rd[1:0]);
				attr.pal <= sf_rd[7:2];
			end
			S_R3:
			begin
				attr.ypos[8] <= sf_rd[7];
				attr.ysize4 <= sf_rd[6:0];
			end
			S_R2: attr.ypos[7:0] <= sf_rd;
			S_R1:
			begin
				attr.xpos[8] <= sf_rd[7];
				attr.xwords <= sf_rd[6:0];
			end
			S_R0: attr.xpos[7:0] <= sf_rd;
			S_R5: attr.base[7:0] <= sf_rd;
			S_R6: attr.base[15:8] <= sf_rd;
			S_R7:
			begin
				attr.base[20:16] <= sf_rd[4:0];
				spu_addr <= {sf_rd[4:0], attr.base[15:0]} + row_ofs;
			end
			S_WAIT:
				if (spu_strobe)
					spu_addr <= spu_addr + 21'd1;	// next word of row
			default: ;
		endcase

	// --------------------
	// datapath control
	// --------------------
	assign cnt_load_word = (state == S_WAIT) && spu_strobe;
	assign cnt_load_row = (state == S_R7);
	assign cnt_step = (state == S_UNPK);
	assign xwords = attr.xwords;
	assign mode = attr.mode;

	assign unpack_ctl = '{
		load:      cnt_load_word,
		mode:      attr.mode,
		pal:       attr.pal,
		xpos_load: (state == S_R7),
		xpos:      attr.xpos
	};

endmodule

//--- src/pixel_counter.sv
`timescale 1ns/10ps

module pixel_counter import spu_pkg::*;
(
	input  logic        clk,
	input  logic        line_start,
	input  color_mode_t mode,
	input  logic [6:0]  xwords,
	input  logic        load_row,
	input  logic        load_word,
	input  logic        step,
	output logic        last_pix,
	output logic        last_word
);

	logic [2:0] pix_cnt;	// pixels left in word, minus one
	logic [6:0] word_cnt;	// words left after current one
	logic [2:0] pix_init;

	// 8, 4 or 2 pixels per word
	always_comb
		case (mode)
			CM_16C: pix_init = 3'd3;
			CM_TRUE: pix_init = 3'd1;
			default: pix_init = 3'd7;
		endcase

	always_ff @(posedge clk or posedge line_start)
		if (line_start)
		begin
			pix_cnt <= 3'd0;
			word_cnt <= 7'd0;
		end
		else
		begin
			if (load_word)
				pix_cnt <= pix_init;
			else if (step && (pix_cnt != 3'd0))
				pix_cnt <= pix_cnt - 3'd1;

			if (load_row)
				word_cnt <= xwords;	// 0 gives 128 words
			else if (load_word)
				word_cnt <= word_cnt - 7'd1;
		end

	assign last_pix = (pix_cnt == 3'd0);
	assign last_word = (word_cnt == 7'd0);

endmodule

//--- src/pixel_unpack.sv
`timescale 1ns/10ps

module pixel_unpack import spu_pkg::*;
(
	input  logic        clk,
	input  logic        line_start,
	input  unpack_ctl_t ctl,
	input  logic [15:0] spu_data,
	input  logic        step,
	output logic [7:0]  sp_ra,
	input  logic [7:0]  sp_rd,
	output logic [8:0]  wr_addr,
	output pix_entry_t  wr_data,
	output logic        wr_en
);

	fetch_word_u word;		// current field always on top
	logic [8:0]  xcur;
	logic        pix_opaque;
	logic [5:0]  pix_color;

	// --------------------
	// word and position
	// --------------------
	always_ff @(posedge clk)
		if (ctl.load)
			word <= spu_data;
		else if (step)
			case (ctl.mode)
				CM_4C: word <= word << 2;
				CM_16C: word <= word << 4;
				default: word <= word << 8;	// direct colour, one byte
			endcase

	// transparent pixels still advance
	always_ff @(posedge clk)
		if (ctl.xpos_load)
			xcur <= ctl.xpos;
		else if (step)
			xcur <= xcur + 9'd1;

	// palette lookup
	always_comb
		case (ctl.mode)
			CM_4C: sp_ra = {ctl.pal, word.idx2[7]};
			CM_16C: sp_ra = {ctl.pal[5:2], word.idx4[3]};
			default: sp_ra = {ctl.pal, 2'b00};	// not looked up
		endcase

	// colour and opacity of the top field
	always_comb
		if (ctl.mode == CM_TRUE)
		begin
			pix_opaque = !word.tc[1].transp;
			pix_color = word.tc[1].color;
		end
		else
		begin
			pix_opaque = !sp_rd[6];		// bit 6 marks transparent
			pix_color = sp_rd[5:0];
		end

	// --------------------
	// line buffer write
	// --------------------
	always_ff @(posedge clk or posedge line_start)
		if (line_start)
			wr_en <= 1'b0;
		else
			wr_en <= step && pix_opaque;

	always_ff @(posedge clk)
	begin
		wr_addr <= xcur;
		wr_data <= '{opaque: 1'b1, color: pix_color};
	end

endmodule

//--- src/line_store.sv
`timescale 1ns/10ps

module line_store import spu_pkg::*;
#(
	parameter int LINE_PIXELS = 360
)
(
	input  logic       clk,
	input  logic       line_start,
	input  logic       draw_sel,
	input  logic [8:0] wr_addr,
	input  pix_entry_t wr_data,
	input  logic       wr_en,
	output logic [5:0] spixel,
	output logic       spx_en
);

	logic [1:0] phase;		// 4-clock scan cadence
	logic [9:0] rd_cnt;		// pixel being shown
	logic       rd_done;
	logic       rd_step;
	pix_entry_t show_q;

	assign rd_done = (rd_cnt >= 10'(LINE_PIXELS));
	assign rd_step = (phase == 2'd0) && !rd_done;	// read and clear

	// --------------------
	// two halves
	// --------------------
	for (genvar h = 0; h < 2; h++)
	begin : g_half
		pix_entry_t mem [512];
		pix_entry_t q;		// read latch, shown half only
		logic       draw_here;
		logic       we;
		logic [8:0] wa;
		pix_entry_t wd;

		assign draw_here = (draw_sel == 1'(h));

		// drawing half takes sprite pixels, shown half clears behind the read
		assign we = draw_here ? wr_en : rd_step;
		assign wa = draw_here ? wr_addr : rd_cnt[8:0];
		assign wd = draw_here ? wr_data : '0;

		always_ff @(posedge clk)
		begin
			if (we)
				mem[wa] <= wd;
			if (!draw_here && rd_step)
				q <= mem[rd_cnt[8:0]];	// old data, clear lands same edge
		end
	end

	assign show_q = draw_sel ? g_half[0].q : g_half[1].q;

	// --------------------
	// scan out
	// --------------------
	// step 0 reads, step 3 presents and moves on
	always_ff @(posedge clk or posedge line_start)
		if (line_start)
		begin
			phase <= 2'd0;
			rd_cnt <= 10'd0;
			spixel <= 6'd0;
			spx_en <= 1'b0;
		end
		else
		begin
			phase <= phase + 2'd1;
			if (phase == 2'd3)
			begin
				if (rd_done)
				begin
					spixel <= 6'd0;		// past the visible line
					spx_en <= 1'b0;
				end
				else
				begin
					spixel <= show_q.color;
					spx_en <= show_q.opaque;
					rd_cnt <= rd_cnt + 10'd1;
				end
			end
		end

endmodule

//--- src/sprite_unit.sv
`timescale 1ns/10ps

module sprite_unit import spu_pkg::*;
#(
	parameter int SPRITE_CNT  = 64,
	parameter int LINE_PIXELS = 360
)
(
	input  logic        clk,
	input  logic        line_start,
	input  logic        pre_vline,
	// sprite file
	output logic [8:0]  sf_ra,
	input  logic [7:0]  sf_rd,
	// palette
	output logic [7:0]  sp_ra,
	input  logic [7:0]  sp_rd,
	// dram
	output logic [20:0] spu_addr,
	output logic        spu_req,
	input  logic        spu_strobe,
	input  logic [15:0] spu_data,
	// video
	output logic [5:0]  spixel,
	output logic        spx_en
);

	unpack_ctl_t unpack_ctl;
	color_mode_t mode;
	logic [6:0]  xwords;
	logic        draw_sel;
	logic        cnt_load_word, cnt_load_row, cnt_step;
	logic        last_pix, last_word;
	logic [8:0]  wr_addr;
	pix_entry_t  wr_data;
	logic        wr_en;

	// --------------------
	// control
	// --------------------
	sprite_seq #(
		.SPRITE_CNT (SPRITE_CNT)
	) u_seq (
		.clk           (clk),
		.line_start    (line_start),
		.pre_vline     (pre_vline),
		.sf_ra         (sf_ra),
		.sf_rd         (sf_rd),
		.spu_addr      (spu_addr),
		.spu_req       (spu_req),
		.spu_strobe    (spu_strobe),
		.last_pix      (last_pix),
		.last_word     (last_word),
		.draw_sel      (draw_sel),
		.unpack_ctl    (unpack_ctl),
		.cnt_load_word (cnt_load_word),
		.cnt_load_row  (cnt_load_row),
		.cnt_step      (cnt_step),
		.xwords        (xwords),
		.mode          (mode)
	);

	pixel_counter u_cnt (
		.clk        (clk),
		.line_start (line_start),
		.mode       (mode),
		.xwords     (xwords),
		.load_row   (cnt_load_row),
		.load_word  (cnt_load_word),
		.step       (cnt_step),
		.last_pix   (last_pix),
		.last_word  (last_word)
	);

	// --------------------
	// data
	// --------------------
	pixel_unpack u_unpack (
		.clk        (clk),
		.line_start (line_start),
		.ctl        (unpack_ctl),
		.spu_data   (spu_data),
		.step       (cnt_step),		// same pulse as counter
		.sp_ra      (sp_ra),
		.sp_rd      (sp_rd),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_en      (wr_en)
	);

	line_store #(
		.LINE_PIXELS (LINE_PIXELS)
	) u_store (
		.clk        (clk),
		.line_start (line_start),
		.draw_sel   (draw_sel),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_en      (wr_en),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule

//--- testbench/sprite_unit_assertions.sv
`timescale 1ns/10ps

module sprite_unit_assertions
(
	input logic        clk,
	input logic        line_start,
	input logic        spu_req,
	input logic        spu_strobe,
	input logic [20:0] spu_addr,
	input logic        wr_en,
	input logic        spx_en
);

	int fail_cnt = 0;	// failed assertion count

	// --------------------
	// dram handshake
	// --------------------
	strobe_needs_req: assert property (@(posedge clk) disable iff (line_start)
		spu_strobe |-> spu_req)
	else
	begin
		$error("spu_strobe arrived with no request pending");
		fail_cnt++;
	end

	// word taken, request dropped and address moved on
	req_drops: assert property (@(posedge clk) disable iff (line_start)
		spu_strobe |=> !spu_req && (spu_addr == $past(spu_addr) + 21'd1))
	else
	begin
		$error("spu_req or spu_addr wrong after strobe");
		fail_cnt++;
	end

	// outputs quiet while in reset
	reset_quiet: assert property (@(posedge clk)
		line_start |=> !spu_req && !wr_en && !spx_en)
	else
	begin
		$error("outputs active after line_start");
		fail_cnt++;
	end

endmodule

bind sprite_unit sprite_unit_assertions u_assert (
	.clk        (clk),
	.line_start (line_start),
	.spu_req    (spu_req),
	.spu_strobe (spu_strobe),
	.spu_addr   (spu_addr),
	.wr_en      (wr_en),
	.spx_en     (spx_en)
);

//--- testbench/sprite_unit_tb.sv
`timescale 1ns/10ps

module sprite_unit_tb import spu_pkg::*;
();

	localparam int SPRITE_CNT  = 64;
	localparam int LINE_PIXELS = 360;
	localparam int CLK_PERIOD  = 4;
	localparam int LINE_CYCLES = 1500;
	localparam int EXTRA_PIX   = 4;		// windows checked past the visible line
	localparam int NUM_TESTS   = 5;
	localparam int START_LINES = 2;
	localparam int WATCHDOG_NS = (NUM_TESTS * 4 + START_LINES) * LINE_CYCLES * CLK_PERIOD;

	logic        clk;
	logic        line_start;
	logic        pre_vline;
	logic [8:0]  sf_ra;
	logic [7:0]  sf_rd;
	logic [7:0]  sp_ra;
	logic [7:0]  sp_rd;
	logic [20:0] spu_addr;
	logic        spu_req;
	logic        spu_strobe;
	logic [15:0] spu_data;
	logic [5:0]  spixel;
	logic        spx_en;

	// --------------------
	// memory models
	// --------------------
	logic [7:0]  sf_mem [SPRITE_CNT * SF_REGS];
	logic [7:0]  pal_mem [256];
	logic [15:0] dram [4096];

	pix_entry_t  model_buf [2][512];	// expected ping-pong halves
	int          m_vline;
	logic        m_sel;				// half being drawn

	logic [7:0]  lfsr;
	logic        mem_busy;
	int          mem_wait;
	logic        ls_seen;			// line_start at the clock edge

	int checks, errors, test_errs, tests_run, tests_failed;

	assign sf_rd = sf_mem[sf_ra];		// same-cycle reads
	assign sp_rd = pal_mem[sp_ra];

	sprite_unit #(
		.SPRITE_CNT  (SPRITE_CNT),
		.LINE_PIXELS (LINE_PIXELS)
	) u_sprite_unit (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.sf_ra      (sf_ra),
		.sf_rd      (sf_rd),
		.sp_ra      (sp_ra),
		.sp_rd      (sp_rd),
		.spu_addr   (spu_addr),
		.spu_req    (spu_req),
		.spu_strobe (spu_strobe),
		.spu_data   (spu_data),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
		lfsr = {lfsr[6:0], fb};
		return fb;
	endfunction

	// dram answers a request after 1 to 8 clocks
	always @(posedge clk)
	begin
		ls_seen = line_start;
		#1;
		spu_strobe = 1'b0;		// one-cycle pulse
		if (ls_seen)
			mem_busy = 1'b0;
		else
		begin
			if (spu_req === 1'b1 && !mem_busy)
			begin
				mem_busy = 1'b1;
				mem_wait = {lfsr_step(), lfsr_step(), lfsr_step()} + 1;
			end
			if (mem_busy)
			begin
				mem_wait = mem_wait - 1;
				if (mem_wait == 0)
				begin
					spu_strobe = 1'b1;
					spu_data = dram[spu_addr[11:0]];
					mem_busy = 1'b0;
				end
			end
		end
	end

	// --------------------
	// helpers
	// --------------------
	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d mismatches", name, test_errs);
		end
		test_errs = 0;
	endtask

	function automatic sprite_attr_t make_attr(input int xpos, input int xwords, input int ypos,
		input int ysize4, input int pal, input color_mode_t mode, input int base);
		sprite_attr_t a;
		a.xpos = 9'(xpos);
		a.xwords = 7'(xwords);
		a.ypos = 9'(ypos);
		a.ysize4 = 7'(ysize4);
		a.pal = 6'(pal);
		a.mode = mode;
		a.base = 21'(base);
		return a;
	endfunction

	// sprite file layout, 8 registers per sprite
	task automatic set_sprite(input int n, input sprite_attr_t a);
		int b;
		b = n * SF_REGS;
		sf_mem[b] = a.xpos[7:0];
		sf_mem[b + 1] = {a.xpos[8], a.xwords};
		sf_mem[b + 2] = a.ypos[7:0];
		sf_mem[b + 3] = {a.ypos[8], a.ysize4};
		sf_mem[b + 4] = {a.pal, a.mode};
		sf_mem[b + 5] = a.base[7:0];
		sf_mem[b + 6] = a.base[15:8];
		sf_mem[b + 7] = {3'b000, a.base[20:16]};
	endtask

	task automatic clear_sprites();
		for (int i = 0; i < SPRITE_CNT * SF_REGS; i++)
			sf_mem[i] = 8'h00;	// mode 0 is off
	endtask

	// --------------------
	// reference line painter
	// --------------------
	task automatic paint_line(input int v, input logic sel);
		int b, xpos, xw, ypos, ys, pal, md, row, x, nf, base;
		logic [15:0] d;
		logic [7:0]  e;
		for (int n = 0; n < SPRITE_CNT; n++)
		begin
			b = n * SF_REGS;
			xpos = {sf_mem[b + 1][7], sf_mem[b]};
			xw = sf_mem[b + 1][6:0];
			ypos = {sf_mem[b + 3][7], sf_mem[b + 2]};
			ys = sf_mem[b + 3][6:0];
			pal = sf_mem[b + 4][7:2];
			md = sf_mem[b + 4][1:0];
			base = {sf_mem[b + 7][4:0], sf_mem[b + 6], sf_mem[b + 5]};
			if (md == CM_OFF || v < ypos || v >= ypos + 4 * ys)
				continue;		// inactive or not on this line
			row = base + xw * (v - ypos);
			x = xpos;
			nf = (md == CM_4C) ? 8 : (md == CM_16C) ? 4 : 2;
			for (int w = 0; w < xw; w++)
			begin
				d = dram[(row + w) % 4096];
				for (int f = 0; f < nf; f++)
				begin
					if (md == CM_4C)
						e = pal_mem[pal * 4 + ((d >> (14 - 2 * f)) & 3)];
					else if (md == CM_16C)
						e = pal_mem[(pal / 4) * 16 + ((d >> (12 - 4 * f)) & 15)];
					else
						e = 8'(d >> (8 - 8 * f));	// direct byte
					if (!e[6])
						model_buf[sel][x] = '{opaque: 1'b1, color: e[5:0]};
					x = (x + 1) % 512;
				end
			end
		end
	endtask

	// one line: pulse, update model, sample each pixel window
	task automatic run_line(input logic pre, input logic check);
		pix_entry_t shown [LINE_PIXELS];
		pix_entry_t exp;
		int waited;
		@(posedge clk);
		#1;
		line_start = 1'b1;
		pre_vline = pre;
		@(posedge clk);
		#1;
		line_start = 1'b0;
		pre_vline = 1'b0;
		if (pre)
		begin
			m_vline = 0;
			m_sel = 1'b0;
		end
		else
		begin
			m_vline = m_vline + 1;
			m_sel = ~m_sel;
		end
		for (int i = 0; i < LINE_PIXELS; i++)
		begin
			shown[i] = model_buf[!m_sel][i];
			model_buf[!m_sel][i] = '0;	// cleared behind the read
		end
		paint_line(m_vline, m_sel);
		repeat (6) @(posedge clk);		// 4 edges to first pixel, 2 into window
		#1;
		waited = 6;
		for (int k = 0; k < LINE_PIXELS + EXTRA_PIX; k++)
		begin
			exp = (k < LINE_PIXELS) ? shown[k] : '0;
			if (check)
			begin
				check_val(spx_en, exp.opaque, $sformatf("spx_en at pixel %0d", k));
				check_val(spixel, exp.color, $sformatf("spixel at pixel %0d", k));
			end
			repeat (4) @(posedge clk);
			#1;
			waited += 4;
		end
		repeat (LINE_CYCLES - 2 - waited) @(posedge clk);
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic test_empty();
		clear_sprites();
		set_sprite(4, make_attr(30, 2, 0, 127, 6'h08, CM_16C, 12'h080));
		run_line(1'b0, 1'b1);	// shows an all-off line
		clear_sprites();
		run_line(1'b0, 1'b1);	// sprite line
		run_line(1'b0, 1'b1);
		run_line(1'b0, 1'b1);	// sprite half again, must be empty now
		end_test("empty lines and clear");
	endtask

	task automatic test_16c();
		clear_sprites();
		dram[12'h100] = 16'h0123;	// every 4-bit index once
		dram[12'h101] = 16'h4567;
		dram[12'h102] = 16'h89ab;
		dram[12'h103] = 16'hcdef;
		set_sprite(5, make_attr(20, 4, 0, 127, 6'b101100, CM_16C, 12'h100));
		run_line(1'b0, 1'b1);
		run_line(1'b0, 1'b1);
		end_test("16-colour sprite");
	endtask

	task automatic test_4c_true();
		clear_sprites();
		dram[12'h200] = 16'h1b1b;
		dram[12'h201] = 16'he4e4;
		dram[12'h202] = 16'h0f96;
		dram[12'h300] = 16'h0540;	// low byte transparent
		dram[12'h301] = 16'h4521;	// high byte transparent
		dram[12'h302] = 16'h3f7f;
		dram[12'h303] = 16'h1200;
		set_sprite(2, make_attr(40, 3, 0, 127, 6'h15, CM_4C, 12'h200));
		set_sprite(9, make_attr(150, 4, 0, 127, 0, CM_TRUE, 12'h300));
		run_line(1'b0, 1'b1);
		run_line(1'b0, 1'b1);
		end_test("4-colour and direct sprites");
	endtask

	task automatic test_rows();
		int v;
		v = m_vline;
		clear_sprites();
		for (int i = 0; i < 12; i++)
		begin
			dram[12'h500 + i] = {2'b00, 6'(i + 1), 2'b00, 6'(i + 33)};	// distinct per word
			dram[12'h600 + i] = {2'b00, 6'(i + 17), 2'b00, 6'(i + 49)};
		end
		set_sprite(0, make_attr(10, 2, v + 2, 1, 0, CM_TRUE, 12'h500));		// starts below
		set_sprite(1, make_attr(200, 3, v - 2, 1, 0, CM_TRUE, 12'h600));	// ends above
		run_line(1'b0, 1'b1);
		run_line(1'b0, 1'b1);
		run_line(1'b0, 1'b1);
		run_line(1'b0, 1'b1);
		end_test("visibility and row address");
	endtask

	task automatic test_overlap();
		clear_sprites();
		dram[12'h380] = 16'h2468;
		dram[12'h381] = 16'hace0;
		dram[12'h390] = 16'h1525;	// all opaque
		dram[12'h391] = 16'h2a3f;
		dram[12'h392] = 16'h0c31;
		dram[12'h393] = 16'h3e07;
		for (int i = 0; i < 16; i++)
			dram[12'h700 + i] = {2'b00, 6'(i + 5), 2'b00, 6'(i + 40)};	// one word per vline
		set_sprite(3, make_attr(100, 2, 0, 127, 6'h20, CM_16C, 12'h380));
		set_sprite(7, make_attr(104, 4, 0, 127, 0, CM_TRUE, 12'h390));
		set_sprite(10, make_attr(300, 1, 0, 127, 0, CM_TRUE, 12'h700));
		run_line(1'b1, 1'b1);	// vline back to 0
		run_line(1'b0, 1'b1);
		run_line(1'b1, 1'b1);
		run_line(1'b0, 1'b1);	// row 0 shown again
		end_test("overlap and pre_vline");
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial
	begin
		clk = 1'b0;
		line_start = 1'b1;
		pre_vline = 1'b1;
		spu_strobe = 1'b0;
		spu_data = 16'h0000;
		lfsr = 8'd71;
		mem_busy = 1'b0;
		mem_wait = 0;
		checks = 0;
		errors = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		m_vline = 0;
		m_sel = 1'b0;
		clear_sprites();
		for (int a = 0; a < 256; a++)
			pal_mem[a] = {1'b0, (a[1:0] == 2'd1), 6'(a[5:0] ^ {a[7:6], a[7:4]})};
		for (int a = 0; a < 4096; a++)
			dram[a] = 16'(a * 16'h9e37) ^ 16'(a >> 4);
		for (int h = 0; h < 2; h++)
			for (int i = 0; i < 512; i++)
				model_buf[h][i] = '0;
		repeat (10) @(posedge clk);
		#1;
		line_start = 1'b0;
		pre_vline = 1'b0;
		repeat (LINE_CYCLES - 10) @(posedge clk);
		run_line(1'b0, 1'b0);	// flushes the half left over from power-up
		test_empty();
		test_16c();
		test_4c_true();
		test_rows();
		test_overlap();
		errors += u_sprite_unit.u_assert.fail_cnt;
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, u_sprite_unit.u_assert.fail_cnt);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// watchdog, all lines plus start-up
	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish in the expected time");
		$display("sim failed");
		$finish;
	end

endmodule

//--- files.f
src/spu_pkg.sv
src/sprite_seq.sv
src/pixel_counter.sv
src/pixel_unpack.sv
src/line_store.sv
src/sprite_unit.sv
testbench/sprite_unit_assertions.sv
testbench/sprite_unit_tb.sv
